// ==== cmd_decode.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "user_io_macros.svh"

module cmd_decode (
    input  wire logic                   clk_sys,
    input  wire logic                   rx_valid,
    input  wire user_io_pkg::spi_byte_t rx_word,
    output user_io_pkg::wr_op_t         wr_op
);

    import user_io_pkg::*;

    // command of the transfer in progress
    logic [7:0] cmd_q = 8'h00;
    // set once the first data byte went through
    // starts set so stray bytes before any command do nothing
    logic       data_seen = 1'b1;
    wr_op_t     op_next;
    wr_op_t     op_q = '0;

    // map the first data byte to a register
    always_comb begin
        op_next      = '0;
        op_next.data = rx_word.data;
        if (rx_valid && !rx_word.first && !data_seen) begin
            op_next.valid = 1'b1;
            case (cmd_q)
                `CMD_BUT_SW:  op_next.target = sel_but_sw;
                `CMD_JOY0:    op_next.target = sel_joy0;
                `CMD_JOY1:    op_next.target = sel_joy1;
                `CMD_KBD_IN:  op_next.target = sel_kbd_in;
                // reading the keyboard acknowledges the pending byte
                `CMD_KBD_OUT: op_next.target = sel_kbd_ack;
                // other joysticks and unknown commands
                default:      op_next.valid = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        op_q <= op_next;
        if (rx_valid) begin
            if (rx_word.first) begin
                cmd_q     <= rx_word.data;
                data_seen <= 1'b0;
            end else begin
                // extra data bytes of the same transfer are dropped
                data_seen <= 1'b1;
            end
        end
    end

    assign wr_op = op_q;

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module io_regs (
    input  wire logic                clk_sys,
    input  wire user_io_pkg::wr_op_t wr_op,
    input  wire logic                kbd_out_strobe,
    output user_io_pkg::but_sw_t     but_sw,
    output logic [7:0]               joy0,
    output logic [7:0]               joy1,
    output logic [7:0]               kbd_in_data,
    output logic                     kbd_in_strobe,
    output logic                     kbd_avail
);

    import user_io_pkg::*;

    // everything comes up zero at configuration
    but_sw_t    but_sw_q = '0;
    logic [7:0] joy0_q = 8'h00;
    logic [7:0] joy1_q = 8'h00;
    logic [7:0] kbd_data_q = 8'h00;
    logic       kbd_strobe_q = 1'b0;
    // core has a keyboard byte waiting for the microcontroller
    logic       kbd_avail_q = 1'b0;

    always_ff @(posedge clk_sys) begin
        // single cycle pulse
        kbd_strobe_q <= 1'b0;
        if (wr_op.valid) begin
            case (wr_op.target)
                sel_but_sw: but_sw_q <= but_sw_t'(wr_op.data);
                sel_joy0:   joy0_q <= wr_op.data;
                sel_joy1:   joy1_q <= wr_op.data;
                sel_kbd_in: begin
                    kbd_data_q   <= wr_op.data;
                    kbd_strobe_q <= 1'b1;
                end
                sel_kbd_ack: kbd_avail_q <= 1'b0;
                default: ;
            endcase
        end
        // new byte from the core wins over an ack in the same cycle
        if (kbd_out_strobe) begin
            kbd_avail_q <= 1'b1;
        end
    end

    assign but_sw        = but_sw_q;
    assign joy0          = joy0_q;
    assign joy1          = joy1_q;
    assign kbd_in_data   = kbd_data_q;
    assign kbd_in_strobe = kbd_strobe_q;
    assign kbd_avail     = kbd_avail_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the user_io testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f user_io.f --top-module tb_user_io -o sim_user_io

# exit status of the simulation is the result
./obj_dir/sim_user_io

// ==== spi_byte_sync.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "user_io_macros.svh"

module spi_byte_sync (
    input  wire logic                   clk_sys,
    input  wire user_io_pkg::spi_byte_t rx_byte,
    input  wire logic                   rx_toggle,
    output logic                        rx_valid,
    output user_io_pkg::spi_byte_t      rx_word
);

    // toggle synchronizer chain, oldest sample at the top
    logic [`SYNC_STAGES-1:0] sync_q = '0;
    // last synchronized toggle level
    logic                    prev_q = 1'b0;
    logic                    valid_q = 1'b0;
    // a new byte was completed on the SPI side
    logic                    change;

    assign change = sync_q[`SYNC_STAGES-1] ^ prev_q;

    always_ff @(posedge clk_sys) begin
        sync_q  <= {sync_q[`SYNC_STAGES-2:0], rx_toggle};
        prev_q  <= sync_q[`SYNC_STAGES-1];
        valid_q <= change;
        // byte has been stable for several clk_sys cycles here
        if (change) begin
            rx_word <= rx_byte;
        end
    end

    // one clk_sys cycle per received byte
    assign rx_valid = valid_q;

endmodule

`default_nettype wire

// ==== spi_miso_tx.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "user_io_macros.svh"

module spi_miso_tx (
    input  wire logic                    SPI_CLK,
    input  wire logic                    SPI_SS_IO,
    input  wire user_io_pkg::frame_pos_t frame_pos,
    input  wire logic                    kbd_avail,
    input  wire logic [7:0]              kbd_out_data,
    output logic                         spi_miso
);

    localparam logic [7:0] core_type = `CORE_TYPE;

    // tag nibble, three zeros, then the data-available flag
    logic [7:0] kbd_status;
    // bit to drive next
    logic [2:0] bit_sel;

    assign kbd_status = {`KBD_STATUS_TAG, 3'b000, kbd_avail};
    // bit counter already counts the edges seen, inverted it walks 7 down to 0
    assign bit_sel = ~frame_pos.bit_idx;

    // falling edge update so the master samples a settled bit on the rising edge
    always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            spi_miso <= 1'b0;
        end else if (frame_pos.byte_idx == 2'd0) begin
            spi_miso <= core_type[bit_sel];
        end else if (frame_pos.cmd == `CMD_KBD_OUT) begin
            // status first then keyboard data for every later byte
            if (frame_pos.byte_idx == 2'd1) begin
                spi_miso <= kbd_status[bit_sel];
            end else begin
                spi_miso <= kbd_out_data[bit_sel];
            end
        end else begin
            // nothing to report for write commands
            spi_miso <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== spi_shift_in.sv ====
`default_nettype none
`timescale 1ns/1ns

module spi_shift_in (
    input  wire logic                SPI_CLK,
    input  wire logic                SPI_SS_IO,
    input  wire logic                spi_mosi,
    output user_io_pkg::spi_byte_t   rx_byte,
    output logic                     rx_toggle,
    output user_io_pkg::frame_pos_t  frame_pos
);

    // first seven bits of the byte in flight
    logic [6:0] sbuf;
    // inverts once per completed byte
    logic       toggle_q = 1'b0;
    // eighth rising edge of a byte
    logic       last_bit;

    assign last_bit = (frame_pos.bit_idx == 3'd7);

    // position counters and command latch
    // everything clears while the slave is deselected
    always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            frame_pos <= '0;
        end else begin
            frame_pos.bit_idx <= frame_pos.bit_idx + 3'd1;
            if (last_bit) begin
                // byte index stops at 2 since later bytes are treated alike
                if (frame_pos.byte_idx != 2'd2) begin
                    frame_pos.byte_idx <= frame_pos.byte_idx + 2'd1;
                end
                // byte 0 is the command, live mosi supplies its lsb
                if (frame_pos.byte_idx == 2'd0) begin
                    frame_pos.cmd <= {sbuf, spi_mosi};
                end
            end
        end
    end

    // msb first shift, byte handed over on the 8th edge
    always_ff @(posedge SPI_CLK) begin
        sbuf <= {sbuf[5:0], spi_mosi};
        if (last_bit) begin
            rx_byte.data  <= {sbuf, spi_mosi};
            rx_byte.first <= (frame_pos.byte_idx == 2'd0);
            // rx_byte holds until the next toggle
            toggle_q      <= ~toggle_q;
        end
    end

    assign rx_toggle = toggle_q;

endmodule

`default_nettype wire

// ==== tb_user_io.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "user_io_macros.svh"

module tb_user_io;

    import user_io_pkg::*;

    logic       clk_sys;
    logic       SPI_CLK;
    logic       SPI_SS_IO;
    logic       spi_mosi;
    logic       spi_miso;
    logic [7:0] joy0;
    logic [7:0] joy1;
    logic       ypbpr;
    logic [1:0] buttons;
    logic [1:0] switches;
    logic [7:0] kbd_out_data;
    logic       kbd_out_strobe;
    logic [7:0] kbd_in_data;
    logic       kbd_in_strobe;

    // bytes sent on mosi and bytes seen on miso in one transfer
    logic [7:0] tx_buf [0:3];
    logic [7:0] rx_buf [0:3];
    // expected register contents
    but_sw_t    exp_but_sw = '0;
    logic [7:0] exp_joy0 = 8'h00;
    logic [7:0] exp_joy1 = 8'h00;
    logic [7:0] exp_kbd_in = 8'h00;
    // kbd_in_strobe pulses seen so far and the data of the last one
    int         strobe_count = 0;
    logic [7:0] strobe_data = 8'h00;
    int         seed = 73501;

    user_io i_user_io (
        .clk_sys        (clk_sys),
        .SPI_CLK        (SPI_CLK),
        .SPI_SS_IO      (SPI_SS_IO),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .joy0           (joy0),
        .joy1           (joy1),
        .ypbpr          (ypbpr),
        .buttons        (buttons),
        .switches       (switches),
        .kbd_out_data   (kbd_out_data),
        .kbd_out_strobe (kbd_out_strobe),
        .kbd_in_data    (kbd_in_data),
        .kbd_in_strobe  (kbd_in_strobe)
    );

    always #10 SPI_CLK = ~SPI_CLK;
    always #3 clk_sys = ~clk_sys;

    // strobe monitor reads pre-edge values so data and strobe line up
    always @(posedge clk_sys) begin
        if (kbd_in_strobe) begin
            strobe_count <= strobe_count + 1;
            strobe_data  <= kbd_in_data;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_but_sw(input string name, input but_sw_t got, input but_sw_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // buttons in bits 1:0, switches in bits 3:2 and ypbpr in bit 5 of the written byte
    function automatic but_sw_t expected_but_sw(input logic [7:0] b);
        but_sw_t e;
        e          = '0;
        e.buttons  = b[1:0];
        e.switches = b[3:2];
        e.ypbpr    = b[5];
        return e;
    endfunction

    // one SPI transfer of n bytes sent msb first with miso read on rising edges
    task automatic spi_transfer(input int n);
        int i;
        int b;
        @(posedge SPI_CLK);
        #2;
        SPI_SS_IO = 1'b0;
        for (i = 0; i < n; i++) begin
            for (b = 7; b >= 0; b--) begin
                spi_mosi = tx_buf[i][b];
                @(posedge SPI_CLK);
                rx_buf[i][b] = spi_miso;
                #2;
            end
        end
        SPI_SS_IO = 1'b1;
        spi_mosi  = 1'b0;
        // every transfer opens with the core identifier
        check_byte("spi_miso byte 0", rx_buf[0], `CORE_TYPE);
    endtask

    // lets the last byte cross into clk_sys
    task automatic settle();
        repeat (10) @(posedge clk_sys);
    endtask

    task automatic wait_kbd_strobe(input int start);
        int t;
        t = 0;
        while (strobe_count == start) begin
            if (t == 50) begin
                fail_run("timeout while waiting for kbd_in_strobe");
            end else begin
                @(posedge clk_sys);
                t++;
            end
        end
    endtask

    // compare all registered outputs with the model
    task automatic check_outputs();
        but_sw_t got;
        // unused and spare bits never reach a port
        got          = '0;
        got.buttons  = buttons;
        got.switches = switches;
        got.ypbpr    = ypbpr;
        check_but_sw("but_sw", got, exp_but_sw);
        check_byte("joy0", joy0, exp_joy0);
        check_byte("joy1", joy1, exp_joy1);
        check_byte("kbd_in_data", kbd_in_data, exp_kbd_in);
        check_bit("kbd_in_strobe", kbd_in_strobe, 1'b0);
    endtask

    task automatic test_but_sw();
        tx_buf[0] = `CMD_BUT_SW;
        tx_buf[1] = random_byte();
        spi_transfer(2);
        settle();
        exp_but_sw = expected_but_sw(tx_buf[1]);
        check_outputs();
    endtask

    task automatic test_joystick();
        tx_buf[0] = `CMD_JOY0;
        tx_buf[1] = random_byte();
        tx_buf[2] = random_byte();
        spi_transfer(3);
        settle();
        // only the first data byte counts
        exp_joy0 = tx_buf[1];
        check_outputs();
        tx_buf[0] = `CMD_JOY1;
        tx_buf[1] = random_byte();
        tx_buf[2] = random_byte();
        spi_transfer(3);
        settle();
        exp_joy1 = tx_buf[1];
        check_outputs();
        // joystick 2 has no output
        tx_buf[0] = 8'h62;
        tx_buf[1] = random_byte();
        spi_transfer(2);
        settle();
        check_outputs();
    endtask

    task automatic test_kbd_write();
        int start;
        start     = strobe_count;
        tx_buf[0] = `CMD_KBD_IN;
        tx_buf[1] = random_byte();
        tx_buf[2] = random_byte();
        spi_transfer(3);
        wait_kbd_strobe(start);
        settle();
        check_byte("kbd_in_strobe pulse count", 8'(strobe_count - start), 8'h01);
        check_byte("kbd_in_data at strobe", strobe_data, tx_buf[1]);
        exp_kbd_in = tx_buf[1];
        check_outputs();
    endtask

    task automatic test_kbd_read();
        kbd_out_data = random_byte();
        @(posedge clk_sys);
        #1;
        kbd_out_strobe = 1'b1;
        @(posedge clk_sys);
        #1;
        kbd_out_strobe = 1'b0;
        settle();
        tx_buf[0] = `CMD_KBD_OUT;
        tx_buf[1] = 8'h00;
        tx_buf[2] = 8'h00;
        spi_transfer(3);
        check_byte("kbd status with data", rx_buf[1], 8'hA1);
        check_byte("kbd_out_data on miso", rx_buf[2], kbd_out_data);
        settle();
        // first read acknowledged the byte
        spi_transfer(2);
        check_byte("kbd status after read", rx_buf[1], 8'hA0);
        settle();
    endtask

    task automatic test_interleaved();
        int         round;
        logic [7:0] sel;
        int         start;
        for (round = 0; round < 12; round++) begin
            sel       = random_byte();
            tx_buf[1] = random_byte();
            start     = strobe_count;
            case (sel[1:0])
                2'd0: begin
                    tx_buf[0]  = `CMD_BUT_SW;
                    exp_but_sw = expected_but_sw(tx_buf[1]);
                end
                2'd1: begin
                    tx_buf[0] = `CMD_JOY0;
                    exp_joy0  = tx_buf[1];
                end
                2'd2: begin
                    tx_buf[0] = `CMD_JOY1;
                    exp_joy1  = tx_buf[1];
                end
                default: begin
                    tx_buf[0]  = `CMD_KBD_IN;
                    exp_kbd_in = tx_buf[1];
                end
            endcase
            spi_transfer(2);
            if (tx_buf[0] == `CMD_KBD_IN) begin
                wait_kbd_strobe(start);
            end
            settle();
            check_outputs();
        end
    endtask

    initial begin
        clk_sys        = 1'b0;
        SPI_CLK        = 1'b0;
        SPI_SS_IO      = 1'b1;
        spi_mosi       = 1'b0;
        kbd_out_data   = 8'h00;
        kbd_out_strobe = 1'b0;
        // slave deselected for two SPI_CLK cycles
        repeat (2) @(posedge SPI_CLK);
        check_bit("spi_miso", spi_miso, 1'b0);
        check_bit("kbd_in_strobe", kbd_in_strobe, 1'b0);
        test_but_sw();
        test_joystick();
        test_kbd_write();
        test_kbd_read();
        test_interleaved();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== user_io.f ====
+incdir+.
user_io_pkg.sv
spi_shift_in.sv
spi_miso_tx.sv
spi_byte_sync.sv
cmd_decode.sv
io_regs.sv
user_io.sv
tb_user_io.sv

// ==== user_io.sv ====
`default_nettype none
`timescale 1ns/1ns

module user_io (
    input  wire logic       clk_sys,
    input  wire logic       SPI_CLK,
    input  wire logic       SPI_SS_IO,
    input  wire logic       spi_mosi,
    output logic            spi_miso,
    output logic [7:0]      joy0,
    output logic [7:0]      joy1,
    output logic            ypbpr,
    output logic [1:0]      buttons,
    output logic [1:0]      switches,
    input  wire logic [7:0] kbd_out_data,
    input  wire logic       kbd_out_strobe,
    output logic [7:0]      kbd_in_data,
    output logic            kbd_in_strobe
);

    import user_io_pkg::*;

    // SPI_CLK side
    spi_byte_t  rx_byte;
    logic       rx_toggle;
    frame_pos_t frame_pos;
    // clk_sys side
    logic       rx_valid;
    spi_byte_t  rx_word;
    wr_op_t     wr_op;
    but_sw_t    but_sw;
    logic       kbd_avail;

    spi_shift_in i_spi_shift_in (
        .SPI_CLK   (SPI_CLK),
        .SPI_SS_IO (SPI_SS_IO),
        .spi_mosi  (spi_mosi),
        .rx_byte   (rx_byte),
        .rx_toggle (rx_toggle),
        .frame_pos (frame_pos)
    );

    // answers on miso while bytes are shifted in
    spi_miso_tx i_spi_miso_tx (
        .SPI_CLK      (SPI_CLK),
        .SPI_SS_IO    (SPI_SS_IO),
        .frame_pos    (frame_pos),
        .kbd_avail    (kbd_avail),
        .kbd_out_data (kbd_out_data),
        .spi_miso     (spi_miso)
    );

    spi_byte_sync i_spi_byte_sync (
        .clk_sys   (clk_sys),
        .rx_byte   (rx_byte),
        .rx_toggle (rx_toggle),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word)
    );

    cmd_decode i_cmd_decode (
        .clk_sys  (clk_sys),
        .rx_valid (rx_valid),
        .rx_word  (rx_word),
        .wr_op    (wr_op)
    );

    io_regs i_io_regs (
        .clk_sys        (clk_sys),
        .wr_op          (wr_op),
        .kbd_out_strobe (kbd_out_strobe),
        .but_sw         (but_sw),
        .joy0           (joy0),
        .joy1           (joy1),
        .kbd_in_data    (kbd_in_data),
        .kbd_in_strobe  (kbd_in_strobe),
        .kbd_avail      (kbd_avail)
    );

    // fields of the buttons/switches byte
    assign buttons  = but_sw.buttons;
    assign switches = but_sw.switches;
    assign ypbpr    = but_sw.ypbpr;

endmodule

`default_nettype wire

// ==== user_io_macros.svh ====
`ifndef USER_IO_MACROS_SVH
`define USER_IO_MACROS_SVH

// identifier sent back as the first byte of every transfer
`define CORE_TYPE 8'hA6

// commands from the microcontroller
`define CMD_BUT_SW  8'h01
`define CMD_KBD_OUT 8'h04
`define CMD_KBD_IN  8'h05
`define CMD_JOY0    8'h60
`define CMD_JOY1    8'h61

// upper nibble of the keyboard status byte
`define KBD_STATUS_TAG 4'hA

// flops in the toggle synchronizer before edge detect
`define SYNC_STAGES 2

`endif

// ==== user_io_pkg.sv ====
`default_nettype none

package user_io_pkg;

    // one received byte as it leaves the SPI_CLK domain
    typedef struct packed {
        logic       first;
        logic [7:0] data;
    } spi_byte_t;

    // register bank destinations
    typedef enum logic [2:0] {
        sel_but_sw,
        sel_joy0,
        sel_joy1,
        sel_kbd_in,
        sel_kbd_ack
    } reg_sel_t;

    // single write into the register bank
    typedef struct packed {
        logic       valid;
        reg_sel_t   target;
        logic [7:0] data;
    } wr_op_t;

    // layout of the buttons/switches byte, bit 0 at the bottom
    typedef struct packed {
        logic [1:0] spare;
        logic       ypbpr;
        logic       unused;
        logic [1:0] switches;
        logic [1:0] buttons;
    } but_sw_t;

    // where the SPI_CLK domain is inside the current transfer
    typedef struct packed {
        logic [1:0] byte_idx;
        logic [2:0] bit_idx;
        logic [7:0] cmd;
    } frame_pos_t;

endpackage

`default_nettype wire
